// File: gmii_pkg.sv
package gmii_pkg;

	// ------------------------------------------------------------
	// Payload types
	// ------------------------------------------------------------
	typedef logic [15:0] pixel_word_t;
	typedef logic [23:0] aux_sample_t;

	// Line geometry and buffering
	localparam int PIXELS_PER_LINE = 32;
	localparam int AUX_BLOCK       = 4;
	localparam int PIX_DEPTH       = 2 * (PIXELS_PER_LINE + 1) + 1;
	localparam int AUX_DEPTH       = 16;
	localparam int IFG_CYCLES      = 12;

	// ------------------------------------------------------------
	// Addresses and fixed header fields
	// ------------------------------------------------------------
	localparam logic [47:0] SRC_MAC       = 48'h00_23_45_67_89_01;
	localparam logic [47:0] DST_MAC       = 48'h00_23_45_67_89_02;
	localparam logic [31:0] SRC_IP        = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] DST_IP        = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT  = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT  = 16'h3039;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

	localparam logic [15:0] IP_VER_TOS  = 16'h4500;
	localparam logic [15:0] IP_IDEN     = 16'h0000;
	localparam logic [15:0] IP_FLAGS    = 16'h4000;
	localparam logic [15:0] IP_TTL_PROT = 16'h4011;

	// Packet type byte
	localparam logic [7:0] PKT_VIDEO = 8'h00;
	localparam logic [7:0] PKT_VIDAX = 8'h02;

	// Header sizes in bytes
	localparam int ETH_HDR_LEN = 14;
	localparam int IP_HDR_LEN  = 20;
	localparam int UDP_HDR_LEN = 8;

	// UDP length: header, type byte, line number, pixels, optional aux block
	localparam logic [15:0] UDP_LEN_VIDEO = 16'(UDP_HDR_LEN + 3 + 2 * PIXELS_PER_LINE);
	localparam logic [15:0] UDP_LEN_VIDAX = UDP_LEN_VIDEO + 16'(3 * AUX_BLOCK);

	// Reflected Ethernet polynomial
	localparam logic [31:0] CRC_POLY = 32'hedb8_8320;

	typedef enum logic [3:0] {
		IDLE, PRE, SFD, ETH, IP, UDP, PTYPE, LINE, PIX, AUX, FCS, GAP
	} tx_state_t;

endpackage

// File: crc32_gen.sv
interface crc_if;
	logic        init;
	logic        data_en;
	logic [7:0]  data;
	logic [31:0] crc;

	modport gen (
		input  init,
		input  data_en,
		input  data,
		output crc
	);

	modport builder (
		output init,
		output data_en,
		output data,
		input  crc
	);
endinterface

module crc32_gen (
	input logic fifo_clk,
	input logic sys_rst,
	crc_if.gen  crc
);
	import gmii_pkg::*;

	logic [31:0] crc_q;
	logic [31:0] crc_nxt;
	logic [31:0] crc_fin;

	// Byte-wide update, LSB first
	always_comb begin
		crc_nxt = crc_q ^ {24'h0, crc.data};
		for (int i = 0; i < 8; i++) begin
			if (crc_nxt[0])
				crc_nxt = (crc_nxt >> 1) ^ CRC_POLY;
			else
				crc_nxt = crc_nxt >> 1;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst || crc.init)
			crc_q <= '1;
		else if (crc.data_en)
			crc_q <= crc_nxt;
	end

	// FCS goes out low byte first, so swap for a high-first reader
	assign crc_fin = ~crc_q;
	assign crc.crc = {crc_fin[7:0], crc_fin[15:8], crc_fin[23:16], crc_fin[31:24]};

endmodule

// File: gmii_frame_tx.sv
interface fifo_pop_if #(
	parameter type payload_t = gmii_pkg::pixel_word_t,
	parameter int  DEPTH     = gmii_pkg::PIX_DEPTH
);
	payload_t                   data;
	logic                       empty;
	logic [$clog2(DEPTH+1)-1:0] level;
	logic                       pop;

	modport fifo (output data, output empty, output level, input pop);
	modport builder (input data, input empty, input level, output pop);
endinterface

module gmii_frame_tx (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        node_id,
	input  logic        line_done,
	fifo_pop_if.builder pix,
	fifo_pop_if.builder aux,
	crc_if.builder      crc,
	output logic        with_aux,
	input  logic [15:0] ip_csum,
	output logic [7:0]  txd,
	output logic        tx_en
);
	import gmii_pkg::*;

	tx_state_t state;
	tx_state_t state_nxt;
	logic [7:0] cnt;
	logic [7:0] cnt_nxt;
	logic [1:0] sub;
	logic [1:0] sub_nxt;
	logic [2:0] pending;
	logic [7:0] byte_nxt;
	logic       en_nxt;
	logic       fold;
	logic       start;

	logic [15:0] udp_len;
	logic [15:0] ip_len;
	logic [7:0]  mac_dst_lo;
	logic [7:0]  mac_src_lo;
	logic [7:0]  ip_src_lo;
	logic [7:0]  ip_dst_lo;
	logic [8*ETH_HDR_LEN-1:0] eth_hdr;
	logic [8*IP_HDR_LEN-1:0]  ip_hdr;
	logic [8*UDP_HDR_LEN-1:0] udp_hdr;

	// ------------------------------------------------------------
	// Header images, first byte in the top bits
	// ------------------------------------------------------------
	assign udp_len    = with_aux ? UDP_LEN_VIDAX : UDP_LEN_VIDEO;
	assign ip_len     = udp_len + 16'(IP_HDR_LEN);
	assign mac_dst_lo = DST_MAC[7:0] - {7'd0, node_id};
	assign mac_src_lo = SRC_MAC[7:0] + {7'd0, node_id};
	assign ip_src_lo  = SRC_IP[7:0] + {7'd0, node_id};
	assign ip_dst_lo  = DST_IP[7:0] - {7'd0, node_id};

	assign eth_hdr = {DST_MAC[47:8], mac_dst_lo, SRC_MAC[47:8], mac_src_lo, ETH_TYPE_IPV4};
	assign ip_hdr  = {IP_VER_TOS, ip_len, IP_IDEN, IP_FLAGS, IP_TTL_PROT, ip_csum,
		SRC_IP[31:8], ip_src_lo, DST_IP[31:8], ip_dst_lo};
	assign udp_hdr = {UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000};

	// ------------------------------------------------------------
	// Next byte, pops and CRC feed
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		cnt_nxt   = cnt + 8'd1;
		sub_nxt   = sub;
		byte_nxt  = 8'h00;
		en_nxt    = 1'b1;
		fold      = 1'b0;
		start     = 1'b0;
		crc.init  = 1'b0;
		pix.pop   = 1'b0;
		aux.pop   = 1'b0;
		case (state)
			IDLE: begin
				en_nxt  = 1'b0;
				cnt_nxt = 8'd1;
				if (pending != '0 && !pix.empty) begin
					// First preamble byte leaves straight from idle
					start     = 1'b1;
					en_nxt    = 1'b1;
					byte_nxt  = 8'h55;
					state_nxt = PRE;
				end
			end
			PRE: begin
				byte_nxt = 8'h55;
				if (cnt == 8'd6) begin
					crc.init  = 1'b1;
					state_nxt = SFD;
				end
			end
			SFD: begin
				byte_nxt  = 8'hd5;
				cnt_nxt   = '0;
				state_nxt = ETH;
			end
			ETH: begin
				byte_nxt = eth_hdr[8 * (ETH_HDR_LEN - 1 - int'(cnt)) +: 8];
				fold     = 1'b1;
				if (cnt == 8'(ETH_HDR_LEN - 1)) begin
					cnt_nxt   = '0;
					state_nxt = IP;
				end
			end
			IP: begin
				byte_nxt = ip_hdr[8 * (IP_HDR_LEN - 1 - int'(cnt)) +: 8];
				fold     = 1'b1;
				if (cnt == 8'(IP_HDR_LEN - 1)) begin
					cnt_nxt   = '0;
					state_nxt = UDP;
				end
			end
			UDP: begin
				byte_nxt = udp_hdr[8 * (UDP_HDR_LEN - 1 - int'(cnt)) +: 8];
				fold     = 1'b1;
				if (cnt == 8'(UDP_HDR_LEN - 1))
					state_nxt = PTYPE;
			end
			PTYPE: begin
				byte_nxt  = with_aux ? PKT_VIDAX : PKT_VIDEO;
				fold      = 1'b1;
				cnt_nxt   = '0;
				state_nxt = LINE;
			end
			LINE, PIX: begin
				// High byte first, pop after the low byte
				byte_nxt = cnt[0] ? pix.data[7:0] : pix.data[15:8];
				pix.pop  = cnt[0];
				fold     = 1'b1;
				if (state == LINE && cnt == 8'd1) begin
					cnt_nxt   = '0;
					state_nxt = PIX;
				end else if (state == PIX && cnt == 8'(2 * PIXELS_PER_LINE - 1)) begin
					cnt_nxt   = '0;
					sub_nxt   = '0;
					state_nxt = with_aux ? AUX : FCS;
				end
			end
			AUX: begin
				fold = 1'b1;
				case (sub)
					2'd0:    byte_nxt = aux.data[23:16];
					2'd1:    byte_nxt = aux.data[15:8];
					default: byte_nxt = aux.data[7:0];
				endcase
				aux.pop = (sub == 2'd2);
				sub_nxt = (sub == 2'd2) ? 2'd0 : sub + 2'd1;
				if (cnt == 8'(3 * AUX_BLOCK - 1)) begin
					cnt_nxt   = '0;
					state_nxt = FCS;
				end
			end
			FCS: begin
				byte_nxt = crc.crc[8 * (3 - int'(cnt)) +: 8];
				if (cnt == 8'd3) begin
					cnt_nxt   = '0;
					state_nxt = GAP;
				end
			end
			GAP: begin
				en_nxt = 1'b0;
				if (cnt == 8'(IFG_CYCLES - 1))
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	assign crc.data    = byte_nxt;
	assign crc.data_en = fold;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= IDLE;
			cnt      <= '0;
			sub      <= '0;
			pending  <= '0;
			with_aux <= 1'b0;
			txd      <= '0;
			tx_en    <= 1'b0;
		end else begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
			sub   <= sub_nxt;
			txd   <= byte_nxt;
			tx_en <= en_nxt;
			// Aux block rides along only if a full block is already waiting
			if (start)
				with_aux <= !aux.empty && (int'(aux.level) >= AUX_BLOCK);
			case ({line_done, start})
				2'b10:   pending <= pending + 3'd1;
				2'b01:   pending <= pending - 3'd1;
				default: ;
			endcase
		end
	end

endmodule

// File: pixel_fifo.sv
module pixel_fifo #(
	parameter type payload_t = gmii_pkg::pixel_word_t,
	parameter int  DEPTH     = gmii_pkg::PIX_DEPTH
) (
	input  logic     fifo_clk,
	input  logic     sys_rst,
	input  logic     push,
	input  payload_t push_data,
	fifo_pop_if.fifo pop
);
	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] level_t;

	payload_t mem [DEPTH];
	ptr_t     wr_ptr;
	ptr_t     rd_ptr;
	ptr_t     rd_nxt;
	level_t   level_q;
	logic     do_push;
	logic     do_pop;

	// Full pushes and empty pops are ignored
	assign do_push = push && (level_q != level_t'(DEPTH));
	assign do_pop  = pop.pop && (level_q != '0);

	always_comb begin
		rd_nxt = rd_ptr;
		if (do_pop)
			rd_nxt = (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
	end

	// Storage and head register; a push into an empty slot goes straight to the head
	always_ff @(posedge fifo_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_push && wr_ptr == rd_nxt)
			pop.data <= push_data;
		else
			pop.data <= mem[rd_nxt];
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			level_q <= '0;
		end else begin
			rd_ptr <= rd_nxt;
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: ;
			endcase
		end
	end

	assign pop.level = level_q;
	assign pop.empty = (level_q == '0);

endmodule

// File: ip_checksum.sv
module ip_checksum (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        with_aux,
	input  logic        node_id,
	output logic [15:0] checksum
);
	import gmii_pkg::*;

	logic [15:0] total_len;
	logic [7:0]  src_lo;
	logic [7:0]  dst_lo;
	logic [19:0] sum_q;
	logic [15:0] folded;

	assign total_len = (with_aux ? UDP_LEN_VIDAX : UDP_LEN_VIDEO) + 16'(IP_HDR_LEN);

	// Same node offsets as the address bytes on the wire
	assign src_lo = SRC_IP[7:0] + {7'd0, node_id};
	assign dst_lo = DST_IP[7:0] - {7'd0, node_id};

	// Checksum field itself counts as zero
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			sum_q <= '0;
		end else begin
			sum_q <= 20'(IP_VER_TOS) + 20'(total_len) + 20'(IP_IDEN) + 20'(IP_FLAGS)
				+ 20'(IP_TTL_PROT)
				+ 20'(SRC_IP[31:16]) + 20'({SRC_IP[15:8], src_lo})
				+ 20'(DST_IP[31:16]) + 20'({DST_IP[15:8], dst_lo});
		end
	end

	// One carry fold is enough for ten words
	assign folded   = sum_q[15:0] + 16'(sum_q[19:16]);
	assign checksum = ~folded;

endmodule

// File: udp_video_tx_top.sv
module udp_video_tx_top (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        node_id,
	input  logic        pix_push,
	input  logic [15:0] pix_data,
	input  logic        line_done,
	input  logic        aux_push,
	input  logic [23:0] aux_data,
	output logic        tx_en,
	output logic [7:0]  txd
);
	import gmii_pkg::*;

	logic        with_aux;
	logic [15:0] ip_csum;

	fifo_pop_if #(.payload_t(pixel_word_t), .DEPTH(PIX_DEPTH)) pix_if ();
	fifo_pop_if #(.payload_t(aux_sample_t), .DEPTH(AUX_DEPTH)) aux_if ();
	crc_if crc_bus ();

	// Line buffer and audio buffer
	pixel_fifo #(.payload_t(pixel_word_t), .DEPTH(PIX_DEPTH)) pix_fifo_inst (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.push      (pix_push),
		.push_data (pix_data),
		.pop       (pix_if)
	);

	pixel_fifo #(.payload_t(aux_sample_t), .DEPTH(AUX_DEPTH)) aux_fifo_inst (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.push      (aux_push),
		.push_data (aux_data),
		.pop       (aux_if)
	);

	ip_checksum ip_checksum_inst (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.with_aux (with_aux),
		.node_id  (node_id),
		.checksum (ip_csum)
	);

	crc32_gen crc32_gen_inst (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc      (crc_bus)
	);

	gmii_frame_tx gmii_frame_tx_inst (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.node_id   (node_id),
		.line_done (line_done),
		.pix       (pix_if),
		.aux       (aux_if),
		.crc       (crc_bus),
		.with_aux  (with_aux),
		.ip_csum   (ip_csum),
		.txd       (txd),
		.tx_en     (tx_en)
	);

endmodule

// File: tb_frame_ref.svh
`ifndef TB_FRAME_REF_SVH
`define TB_FRAME_REF_SVH

typedef logic [7:0]  byte_q_t [$];
typedef logic [15:0] line_t [PIXELS_PER_LINE];
typedef logic [23:0] aux_blk_t [AUX_BLOCK];

// Low n bytes of v, most significant first
function automatic byte_q_t be_bytes(logic [47:0] v, int n);
	byte_q_t q;
	for (int i = n - 1; i >= 0; i--)
		q.push_back(v[8*i +: 8]);
	return q;
endfunction

// Bit-serial Ethernet CRC-32, LSB of each byte first
function automatic logic [31:0] crc32_ref(byte_q_t data);
	logic [31:0] c;
	c = 32'hffff_ffff;
	foreach (data[i]) begin
		for (int b = 0; b < 8; b++) begin
			if (c[0] ^ data[i][b])
				c = (c >> 1) ^ 32'hedb8_8320;
			else
				c = c >> 1;
		end
	end
	return ~c;
endfunction

// Ones' complement sum over a 20-byte header
function automatic logic [15:0] ipv4_csum_ref(byte_q_t hdr);
	logic [31:0] sum;
	sum = '0;
	for (int i = 0; i < 20; i += 2)
		sum = sum + {16'h0, hdr[i], hdr[i + 1]};
	while (sum[31:16] != 16'h0)
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
	return ~sum[15:0];
endfunction

// Whole frame from preamble to FCS
function automatic byte_q_t build_frame_ref(logic [15:0] line_num, line_t pix, aux_blk_t aux,
		logic with_aux, logic node);
	byte_q_t     frame;
	byte_q_t     body;
	byte_q_t     ip;
	logic [15:0] udp_len;
	logic [15:0] ip_len;
	logic [15:0] csum;
	logic [31:0] fcs;
	logic [7:0]  nd;

	nd      = {7'd0, node};
	udp_len = 16'(8 + 3 + 2 * PIXELS_PER_LINE);
	if (with_aux)
		udp_len = udp_len + 16'(3 * AUX_BLOCK);
	ip_len = udp_len + 16'd20;

	body = {be_bytes({DST_MAC[47:8], DST_MAC[7:0] - nd}, 6),
		be_bytes({SRC_MAC[47:8], SRC_MAC[7:0] + nd}, 6), be_bytes({32'h0, 16'h0800}, 2)};

	// Checksum field zero while summing
	ip = {be_bytes({IP_VER_TOS, ip_len, IP_IDEN}, 6),
		be_bytes({IP_FLAGS, IP_TTL_PROT, 16'h0000}, 6),
		be_bytes({SRC_IP[31:8], SRC_IP[7:0] + nd, DST_IP[31:16]}, 6),
		be_bytes({32'h0, DST_IP[15:8], DST_IP[7:0] - nd}, 2)};
	csum   = ipv4_csum_ref(ip);
	ip[10] = csum[15:8];
	ip[11] = csum[7:0];

	body = {body, ip, be_bytes({UDP_SRC_PORT, UDP_DST_PORT, udp_len}, 6),
		be_bytes(48'h0, 2)};
	body = {body, be_bytes({40'h0, with_aux ? PKT_VIDAX : PKT_VIDEO}, 1)};
	body = {body, be_bytes({32'h0, line_num}, 2)};
	for (int i = 0; i < PIXELS_PER_LINE; i++)
		body = {body, be_bytes({32'h0, pix[i]}, 2)};
	if (with_aux) begin
		for (int i = 0; i < AUX_BLOCK; i++)
			body = {body, be_bytes({24'h0, aux[i]}, 3)};
	end

	for (int i = 0; i < 7; i++)
		frame.push_back(8'h55);
	frame.push_back(8'hd5);
	frame = {frame, body};
	fcs   = crc32_ref(body);
	frame = {frame, fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
	return frame;
endfunction

`endif

// File: tb_udp_video_tx.sv
module tb_udp_video_tx;
	timeunit 1ns;
	timeprecision 100ps;

	import gmii_pkg::*;

	`include "tb_frame_ref.svh"

	localparam int NUM_FRAMES = 8;
	localparam int MAX_CYCLES = NUM_FRAMES * 200 + 200;

	logic        fifo_clk = 1'b0;
	logic        sys_rst;
	logic        node_id;
	logic        pix_push;
	logic [15:0] pix_data;
	logic        line_done;
	logic        aux_push;
	logic [23:0] aux_data;
	logic        tx_en;
	logic [7:0]  txd;

	// Flattened expected and captured frames
	logic [7:0] exp_bytes [$];
	int         exp_len [$];
	int         exp_gap [$];
	int         exp_test [$];
	bit         exp_last [$];
	logic [7:0] cap_bytes [$];
	int         cap_len [$];
	int         cap_gap [$];

	int cycles;
	int errors;
	int tests_run;
	int tests_failed;
	int frames_checked;
	int aux_waiting;
	int early_tx;
	int run_len;
	int low_cnt;
	bit in_frame;
	bit seen_frame;
	bit line_started;

	udp_video_tx_top udp_video_tx_top_inst (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.node_id   (node_id),
		.pix_push  (pix_push),
		.pix_data  (pix_data),
		.line_done (line_done),
		.aux_push  (aux_push),
		.aux_data  (aux_data),
		.tx_en     (tx_en),
		.txd       (txd)
	);

	always #2 fifo_clk = ~fifo_clk;

	always @(posedge fifo_clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timed out after %0d cycles, %0d of %0d frames checked",
				cycles, frames_checked, NUM_FRAMES);
			$display("TB FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Frame capture and gap count
	// ------------------------------------------------------------
	always @(negedge fifo_clk) begin
		if (!line_started && (tx_en !== 1'b0 || txd !== 8'h00)) begin
			$display("FAIL t=%0t tx_en %b txd %02h before the first line_done",
				$time, tx_en, txd);
			early_tx++;
		end
		if (tx_en === 1'b1) begin
			if (!in_frame) begin
				cap_gap.push_back(seen_frame ? low_cnt : -1);
				in_frame = 1'b1;
				run_len  = 0;
			end
			cap_bytes.push_back(txd);
			run_len++;
		end else begin
			if (in_frame) begin
				cap_len.push_back(run_len);
				in_frame   = 1'b0;
				seen_frame = 1'b1;
				low_cnt    = 0;
			end
			low_cnt++;
		end
	end

	function automatic string test_label(int id);
		case (id)
			1: return "idle until first line_done";
			2: return "single video line";
			3: return "node id offsets";
			4: return "video with audio block";
			5: return "back to back lines and gap";
			default: return "random lines with mixed audio";
		endcase
	endfunction

	function automatic void report_test(int id, bit ok);
		$display("test %0d (%s): %s", id, test_label(id), ok ? "pass" : "fail");
	endfunction

	// ------------------------------------------------------------
	// Compare against the reference frames
	// ------------------------------------------------------------
	initial begin : compare_frames
		int         got_len;
		int         got_gap;
		int         want_len;
		int         want_gap;
		int         tid;
		bit         last;
		int         diffs;
		int         bad;
		int         test_bad;
		logic [7:0] want;
		logic [7:0] got;
		test_bad = 0;
		forever begin
			while (cap_len.size() == 0)
				@(posedge fifo_clk);
			got_len = cap_len.pop_front();
			got_gap = cap_gap.pop_front();
			if (exp_len.size() == 0) begin
				$display("An unexpected extra frame of %0d bytes was sent at %0t", got_len, $time);
				errors++;
				for (int i = 0; i < got_len; i++)
					void'(cap_bytes.pop_front());
			end else begin
				want_len = exp_len.pop_front();
				want_gap = exp_gap.pop_front();
				tid      = exp_test.pop_front();
				last     = exp_last.pop_front();
				bad      = 0;
				diffs    = 0;
				if (got_len != want_len) begin
					$display("FAIL t=%0t test %0d frame is %0d bytes, expected %0d",
						$time, tid, got_len, want_len);
					bad++;
				end
				if (want_gap >= 0 && got_gap != want_gap) begin
					$display("FAIL t=%0t test %0d gap of %0d cycles, expected %0d",
						$time, tid, got_gap, want_gap);
					bad++;
				end
				for (int i = 0; i < want_len; i++) begin
					want = exp_bytes.pop_front();
					if (i < got_len) begin
						got = cap_bytes.pop_front();
						if (got !== want) begin
							if (diffs == 0)
								$display("FAIL t=%0t test %0d byte %0d is %02h, expected %02h",
									$time, tid, i, got, want);
							diffs++;
						end
					end
				end
				for (int i = want_len; i < got_len; i++)
					void'(cap_bytes.pop_front());
				if (diffs > 1)
					$display("FAIL t=%0t test %0d has %0d differing bytes", $time, tid, diffs);
				bad      = bad + diffs;
				errors   = errors + bad;
				test_bad = test_bad + bad;
				frames_checked++;
				if (last) begin
					tests_run++;
					if (test_bad != 0)
						tests_failed++;
					report_test(tid, test_bad == 0);
					test_bad = 0;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	function automatic line_t ramp_line(logic [15:0] base);
		line_t p;
		for (int i = 0; i < PIXELS_PER_LINE; i++)
			p[i] = base + 16'(i * 257);
		return p;
	endfunction

	function automatic line_t random_line();
		line_t p;
		for (int i = 0; i < PIXELS_PER_LINE; i++)
			p[i] = 16'($urandom);
		return p;
	endfunction

	task automatic drive_line(logic [15:0] line_num, line_t pix);
		@(negedge fifo_clk);
		pix_push = 1'b1;
		pix_data = line_num;
		for (int i = 0; i < PIXELS_PER_LINE; i++) begin
			@(negedge fifo_clk);
			pix_data = pix[i];
		end
		@(negedge fifo_clk);
		pix_push = 1'b0;
	endtask

	// Audio first, then the line, then the expected frame
	task automatic load_line(int test_id, logic [15:0] line_num, line_t pix, aux_blk_t aux,
			bit push_aux, bit last, int gap);
		byte_q_t frame;
		logic    with_aux;
		if (push_aux) begin
			for (int i = 0; i < AUX_BLOCK; i++) begin
				@(negedge fifo_clk);
				aux_push = 1'b1;
				aux_data = aux[i];
			end
			@(negedge fifo_clk);
			aux_push    = 1'b0;
			aux_waiting = aux_waiting + AUX_BLOCK;
		end
		drive_line(line_num, pix);
		// Audio rides along only when a whole block waits at frame start
		with_aux = (aux_waiting >= AUX_BLOCK);
		if (with_aux)
			aux_waiting = aux_waiting - AUX_BLOCK;
		frame = build_frame_ref(line_num, pix, aux, with_aux, node_id);
		foreach (frame[i])
			exp_bytes.push_back(frame[i]);
		exp_len.push_back(frame.size());
		exp_gap.push_back(gap);
		exp_test.push_back(test_id);
		exp_last.push_back(last);
	endtask

	task automatic strobe_line_done();
		@(negedge fifo_clk);
		line_done    = 1'b1;
		line_started = 1'b1;
		@(negedge fifo_clk);
		line_done = 1'b0;
	endtask

	task automatic wait_frames(int n);
		while (frames_checked < n)
			@(negedge fifo_clk);
	endtask

	initial begin : stimulus
		line_t    pix;
		aux_blk_t aux;
		void'($urandom(10));
		sys_rst   = 1'b1;
		node_id   = 1'b0;
		pix_push  = 1'b0;
		pix_data  = '0;
		line_done = 1'b0;
		aux_push  = 1'b0;
		aux_data  = '0;
		repeat (8) @(negedge fifo_clk);
		sys_rst = 1'b0;

		// Pixels waiting without a strobe must not start a frame
		pix = ramp_line(16'h1000);
		aux = '{default: '0};
		load_line(2, 16'd1, pix, aux, 1'b0, 1'b1, -1);
		repeat (4) @(negedge fifo_clk);
		tests_run++;
		if (early_tx != 0)
			tests_failed++;
		report_test(1, early_tx == 0);
		strobe_line_done();
		wait_frames(1);

		node_id = 1'b1;
		load_line(3, 16'd2, ramp_line(16'h2040), aux, 1'b0, 1'b1, -1);
		strobe_line_done();
		wait_frames(2);
		node_id = 1'b0;

		for (int i = 0; i < AUX_BLOCK; i++)
			aux[i] = 24'h10_2030 + 24'(i * 24'h01_0101);
		load_line(4, 16'd3, ramp_line(16'h3333), aux, 1'b1, 1'b1, -1);
		strobe_line_done();
		wait_frames(3);

		// Second line queued while the first is on the wire
		aux = '{default: '0};
		load_line(5, 16'd4, ramp_line(16'h4400), aux, 1'b0, 1'b0, -1);
		strobe_line_done();
		load_line(5, 16'd5, ramp_line(16'h5501), aux, 1'b0, 1'b1, IFG_CYCLES);
		strobe_line_done();
		wait_frames(5);

		for (int k = 0; k < 3; k++) begin
			pix = random_line();
			for (int i = 0; i < AUX_BLOCK; i++)
				aux[i] = 24'($urandom);
			load_line(6, 16'(20 + k), pix, aux, k != 1, k == 2, -1);
			strobe_line_done();
			wait_frames(6 + k);
		end

		repeat (IFG_CYCLES + 8) @(negedge fifo_clk);
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && early_tx == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
gmii_pkg.sv
crc32_gen.sv
gmii_frame_tx.sv
pixel_fifo.sv
ip_checksum.sv
udp_video_tx_top.sv
tb_udp_video_tx.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --timescale 1ns/100ps -f all.f \
	--top-module tb_udp_video_tx -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation did not pass"
exit 1
